//--- include/softmax_cfg.svh
/* Vector and tile sizes plus Q16.16 constants shared by every stage.
   SM_TOTAL need not be a multiple of SM_TILE; the last tile is then padded */
`ifndef SOFTMAX_CFG_SVH
`define SOFTMAX_CFG_SVH

// Element format
`define SM_WIDTH 32                 // Bits per element
`define SM_FRAC  16                 // Fraction bits, Q16.16

// Vector geometry
`define SM_TOTAL 18                 // Elements per vector
`define SM_TILE  4                  // Lanes per tile
// Tiles per vector, rounded up
`define SM_DEPTH ((`SM_TOTAL + `SM_TILE - 1) / `SM_TILE)

// Fixed-point constants in Q16.16
`define SM_LOG2E 32'h00017154       // log2(e)
`define SM_LN2   32'h0000B172       // ln(2)

`endif

//--- list.f
+incdir+include
source/softmax_fixed_pkg.sv
source/softmax_ctrl_pkg.sv
source/tile_buffer.sv
source/exp_tile.sv
source/sum_ln.sv
source/softmax_top.sv
verif/tb_softmax.sv

//--- source/exp_tile.sv
/* Inputs must keep x - offset inside the Q16.16 range; positive differences
   saturate at 1.0. Result registered one cycle after in_valid */
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module exp_tile (
    input  logic                         clk,
    input  logic                         rst_n,
    input  softmax_ctrl_pkg::exp_op_t    op,         // Arrives with in_valid
    input  softmax_fixed_pkg::tile_t     in_tile,
    input  logic                         in_valid,
    input  logic                         last,       // in_tile is the last tile
    input  softmax_fixed_pkg::elem_t     max_val,
    input  softmax_fixed_pkg::elem_t     ln_val,
    input  softmax_fixed_pkg::lane_cnt_t last_lanes,
    output softmax_fixed_pkg::tile_t     exp_tile_q,
    output logic                         exp_valid
);
    import softmax_fixed_pkg::*;
    import softmax_ctrl_pkg::*;

    localparam elem_t ONE = elem_t'(1 << `SM_FRAC);

    elem_t offset;                  // Value subtracted from every lane
    elem_t diff;
    tile_t exp_d;

    // exp(x) = 2^(x*log2e), split into integer shift and linear fraction
    function automatic elem_t exp_q(input elem_t x);
        logic signed [63:0] prod;
        logic signed [47:0] t;
        logic signed [31:0] n;
        logic [31:0]        mant;
        prod = x * $signed({1'b0, `SM_LOG2E});
        t    = 48'(prod >>> `SM_FRAC);                   // Floor, base-2 exponent
        n    = 32'(t >>> `SM_FRAC);                      // Integer part, <= 0
        mant = 32'(ONE) + 32'(t[`SM_FRAC-1:0]);          // 1 + f, linear 2^f
        if (x >= 0) begin
            return ONE;                                  // Positive inputs saturate at one
        end
        if (-n >= 32) begin
            return '0;
        end
        return elem_t'(mant >> (-n));
    endfunction

    always_comb begin
        offset = (op == OP_OUT) ? max_val + ln_val : max_val;
        for (int i = 0; i < `SM_TILE; i++) begin
            diff = elem_t'(in_tile[i]) - offset;
            // Padding of the last tile stays zero in both passes
            if (last && i >= int'(last_lanes)) begin
                exp_d[i] = '0;
            end else begin
                exp_d[i] = exp_q(diff);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            exp_tile_q <= exp_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exp_valid <= 1'b0;
        end else begin
            exp_valid <= in_valid;
        end
    end

    // The sequencer delays op with each read, so every returned tile has an op
    a_op_with_data: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> op != OP_NONE);

endmodule

//--- source/softmax_ctrl_pkg.sv
/* Control encodings of the pass sequencer and the exp stage */
`include "softmax_cfg.svh"

package softmax_ctrl_pkg;

    // Pass sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,                    // Waiting for start
        ST_LOAD,                    // Storing tiles, tracking max
        ST_SUM,                     // Summing exp(x - max), then draining
        ST_LN,                      // One cycle to register ln(sum)
        ST_OUT,                     // Streaming results
        ST_DONE                     // Done pulse cycle
    } seq_state_t;

    // What the exp stage subtracts before the exp
    typedef enum logic [1:0] {
        OP_NONE,
        OP_SUM,                     // x - max
        OP_OUT                      // x - max - ln(sum)
    } exp_op_t;

endpackage

//--- source/softmax_fixed_pkg.sv
/* Numeric types of the datapath. Lane 0 of a tile is the most significant
   word and holds the lowest element index */
`include "softmax_cfg.svh"

package softmax_fixed_pkg;

    // Sum of SM_TOTAL exp values, each at most 1.0
    localparam int SUM_W  = `SM_WIDTH + $clog2(`SM_TOTAL + 1);
    localparam int LANE_W = $clog2(`SM_TILE + 1);
    // Keep at least one address bit for a single-tile vector
    localparam int ADDR_W = $clog2((`SM_DEPTH > 1) ? `SM_DEPTH : 2);

    // Signed Q16.16 element
    typedef logic signed [`SM_WIDTH-1:0] elem_t;

    // One tile, lane 0 in the top word
    typedef logic [0:`SM_TILE-1][`SM_WIDTH-1:0] tile_t;

    // Unsigned Q16.16 accumulator with headroom for the whole vector
    typedef logic [SUM_W-1:0] sum_t;

    // Count of valid lanes, 0 to SM_TILE
    typedef logic [LANE_W-1:0] lane_cnt_t;

    // Tile buffer address
    typedef logic [ADDR_W-1:0] tile_addr_t;

endpackage

//--- source/softmax_top.sv
/* The sink must take one output tile per cycle as there is no back-pressure.
   Input tiles are taken only in the load pass and tile_in_valid is ignored otherwise */
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module softmax_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  softmax_fixed_pkg::tile_t tile_in,
    input  logic                     tile_in_valid,
    output softmax_fixed_pkg::tile_t tile_out,
    output logic                     tile_out_valid,
    output logic                     done
);
    import softmax_fixed_pkg::*;
    import softmax_ctrl_pkg::*;

    localparam tile_addr_t LAST_ADDR = tile_addr_t'(`SM_DEPTH - 1);

    seq_state_t state;
    tile_addr_t tile_cnt;           // Counts loaded tiles and later serves as read address
    logic [1:0] drain_cnt;          // 0 while issuing reads
    exp_op_t    op_q;               // Op of the read in flight
    logic       last_q;             // Read in flight is the last tile
    logic       go, clear, wr_en, rd_en, ln_go, accumulate;
    logic       issue_last;

    tile_t      rd_tile, exp_tile_q;
    logic       rd_valid, exp_valid;
    elem_t      max_val, ln_val;
    lane_cnt_t  last_lanes;

    assign go         = start && (state == ST_IDLE || state == ST_DONE);
    assign clear      = go;                                     // Fresh max and sum
    assign wr_en      = tile_in_valid && state == ST_LOAD;
    assign rd_en      = (state == ST_SUM || state == ST_OUT) && drain_cnt == 2'd0;
    assign issue_last = rd_en && tile_cnt == LAST_ADDR;
    assign accumulate = (state == ST_SUM);
    assign ln_go      = (state == ST_LN);

    assign tile_out       = exp_tile_q;
    assign tile_out_valid = exp_valid && state == ST_OUT;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            tile_cnt  <= '0;
            drain_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE, ST_DONE: begin
                    state    <= go ? ST_LOAD : ST_IDLE;
                    tile_cnt <= '0;
                end
                ST_LOAD: if (wr_en) begin
                    tile_cnt <= (tile_cnt == LAST_ADDR) ? '0 : tile_cnt + 1'b1;
                    if (tile_cnt == LAST_ADDR) begin
                        state <= ST_SUM;                        // Max settles this edge
                    end
                end
                ST_SUM, ST_OUT: begin
                    if (rd_en) begin
                        tile_cnt  <= issue_last ? '0 : tile_cnt + 1'b1;
                        drain_cnt <= issue_last ? 2'd1 : 2'd0;
                    end else if (drain_cnt == 2'd2) begin
                        drain_cnt <= '0;                        // Last tile through exp
                        state     <= (state == ST_SUM) ? ST_LN : ST_DONE;
                        done      <= (state == ST_OUT);
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                ST_LN:   state <= ST_OUT;                       // ln_val ready next cycle
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Op and last flag ride one cycle behind the read alongside rd_valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_q   <= OP_NONE;
            last_q <= 1'b0;
        end else begin
            op_q   <= !rd_en ? OP_NONE : (state == ST_OUT) ? OP_OUT : OP_SUM;
            last_q <= issue_last;
        end
    end

    tile_buffer u_buf (
        .clk(clk), .rst_n(rst_n), .clear(clear), .wr_en(wr_en), .rd_en(rd_en),
        .wr_tile(tile_in), .rd_addr(tile_cnt), .rd_tile(rd_tile), .rd_valid(rd_valid),
        .max_val(max_val), .last_lanes(last_lanes), .full()
    );

    exp_tile u_exp (
        .clk(clk), .rst_n(rst_n), .op(op_q), .in_tile(rd_tile), .in_valid(rd_valid),
        .last(last_q), .max_val(max_val), .ln_val(ln_val), .last_lanes(last_lanes),
        .exp_tile_q(exp_tile_q), .exp_valid(exp_valid)
    );

    sum_ln u_sum (
        .clk(clk), .rst_n(rst_n), .clear(clear), .accumulate(accumulate),
        .exp_tile_q(exp_tile_q), .exp_valid(exp_valid), .ln_go(ln_go), .ln_val(ln_val)
    );

endmodule

//--- source/sum_ln.sv
/* Lanes are taken as unsigned, so exp tiles must be nonnegative.
   ln_val is valid the cycle after ln_go and holds until the next ln_go */
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module sum_ln (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear,          // Start of a new vector
    input  logic                     accumulate,     // Sum pass active
    input  softmax_fixed_pkg::tile_t exp_tile_q,
    input  logic                     exp_valid,
    input  logic                     ln_go,
    output softmax_fixed_pkg::elem_t ln_val
);
    import softmax_fixed_pkg::*;

    sum_t tile_sum;                 // Lane total of the current tile
    sum_t acc;

    // ln(s) = k*ln2 + ln(m), with ln(m) taken as linear in the mantissa
    function automatic elem_t ln_q(input sum_t s);
        int                 p;
        logic [63:0]        norm;
        logic signed [63:0] kk;
        logic signed [63:0] lin;
        logic signed [63:0] prod;
        p = -1;
        for (int b = 0; b < SUM_W; b++) begin
            if (s[b]) begin
                p = b;                          // Leading one
            end
        end
        if (p < 0) begin
            return '0;
        end
        // Bring the leading one to bit SM_FRAC
        if (p >= `SM_FRAC) begin
            norm = 64'(s) >> (p - `SM_FRAC);
        end else begin
            norm = 64'(s) << (`SM_FRAC - p);
        end
        kk   = p - `SM_FRAC;
        lin  = (kk <<< `SM_FRAC) + $signed({48'd0, norm[`SM_FRAC-1:0]});
        prod = lin * $signed({1'b0, `SM_LN2});
        return elem_t'(prod >>> `SM_FRAC);     // Floor
    endfunction

    always_comb begin
        tile_sum = '0;
        for (int i = 0; i < `SM_TILE; i++) begin
            tile_sum = tile_sum + sum_t'(exp_tile_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            acc <= '0;
        end else if (accumulate && exp_valid) begin
            acc <= acc + tile_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (ln_go) begin
            ln_val <= ln_q(acc);
        end
    end

    // The max element alone contributes 1.0, so a zero sum means a lost pass
    a_sum_nonzero: assert property (@(posedge clk) disable iff (!rst_n) ln_go |-> acc != '0);

endmodule

//--- source/tile_buffer.sv
/* Tiles must be written in order, SM_DEPTH per vector; padded lanes of the last
   tile never reach the max. Reads return one cycle after rd_en */
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module tile_buffer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clear,      // New vector, restart writes and max
    input  logic                          wr_en,
    input  logic                          rd_en,
    input  softmax_fixed_pkg::tile_t      wr_tile,
    input  softmax_fixed_pkg::tile_addr_t rd_addr,
    output softmax_fixed_pkg::tile_t      rd_tile,
    output logic                          rd_valid,
    output softmax_fixed_pkg::elem_t      max_val,
    output softmax_fixed_pkg::lane_cnt_t  last_lanes,
    output logic                          full        // All tiles of the vector stored
);
    import softmax_fixed_pkg::*;

    localparam int    LAST_N   = `SM_TOTAL - (`SM_DEPTH - 1) * `SM_TILE;
    localparam elem_t MOST_NEG = {1'b1, {(`SM_WIDTH-1){1'b0}}};

    tile_t      mem [`SM_DEPTH];    // Tile storage
    tile_addr_t wr_addr;
    logic       wr_last;            // This write completes the vector
    lane_cnt_t  wr_lanes;           // Lanes of the incoming tile that count
    elem_t      lane_v;
    elem_t      max_d;

    assign last_lanes = lane_cnt_t'(LAST_N);
    assign wr_last    = (wr_addr == tile_addr_t'(`SM_DEPTH - 1));
    assign wr_lanes   = wr_last ? last_lanes : lane_cnt_t'(`SM_TILE);

    // Fold the valid lanes into the running max
    always_comb begin
        max_d = max_val;
        for (int i = 0; i < `SM_TILE; i++) begin
            lane_v = elem_t'(wr_tile[i]);
            if (i < int'(wr_lanes) && lane_v > max_d) begin
                max_d = lane_v;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            wr_addr <= '0;
            max_val <= MOST_NEG;        // Any element beats this
            full    <= 1'b0;
        end else if (wr_en) begin
            wr_addr <= wr_last ? '0 : wr_addr + 1'b1;
            max_val <= max_d;           // Visible the cycle after the write
            full    <= wr_last;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_tile;
        end
        if (rd_en) begin
            rd_tile <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // Loading must stop once the vector is complete
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full);

endmodule

//--- verif/softmax_tests.txt
# name gap, then 18 input elements and 18 expected outputs, Q16.16 hex
# elements in index order, 9 per line; gap 1 adds random idle input cycles
uniform 0
fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000
fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000 fffe0000
00000f00 00000f00 00000f00 00000f00 00000f00 00000f00 00000f00 00000f00 00000f00
00000f00 00000f00 00000f00 00000f00 00000f00 00000f00 00000f00 00000f00 00000f00
ramp 0
ffec0000 ffee0000 fff00000 fff20000 fff40000 fff60000 fff80000 fffa0000 fffc0000
fffe0000 00000000 00020000 00040000 00060000 00080000 000a0000 000c0000 000e0000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000002 00000014 00000097 00000445 00001f3f 0000eb52
mixed 0
00004000 ffff8000 00018000 fffd0000 ffd80000 00004000 ffff8000 fffd0000 00004000
ffd80000 ffff8000 00018000 fffd0000 00004000 ffff8000 ffd80000 00004000 fffd0000
000012be 000008b7 00003f33 000000bd 00000000 000012be 000008b7 000000bd 000012be
00000000 000008b7 00003f33 000000bd 000012be 000008b7 00000000 000012be 000000bd
ramp_gaps 1
ffec0000 ffee0000 fff00000 fff20000 fff40000 fff60000 fff80000 fffa0000 fffc0000
fffe0000 00000000 00020000 00040000 00060000 00080000 000a0000 000c0000 000e0000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000002 00000014 00000097 00000445 00001f3f 0000eb52

//--- verif/tb_softmax.sv
/* Runs from the project root to find verif/softmax_tests.txt. Padded input
   lanes are driven as zero and padded output lanes must come back zero */
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module tb_softmax;
    import softmax_fixed_pkg::*;

    localparam int WAIT_MAX = 200;                  // Cycles allowed per wait
    localparam int LANES    = `SM_DEPTH * `SM_TILE;

    logic  clk, rst_n, start, tile_in_valid, tile_out_valid, done;
    tile_t tile_in, tile_out;

    int               fd, gap_mode, n_tests;
    int unsigned      seed;
    string            tok, name;
    logic [8*128-1:0] rest;                         // Comment text, dropped
    elem_t            x_vec   [LANES];              // Inputs, zero padded
    elem_t            exp_vec [LANES];              // Expected, zero padded

    softmax_top uut (
        .clk(clk), .rst_n(rst_n), .start(start), .tile_in(tile_in),
        .tile_in_valid(tile_in_valid), .tile_out(tile_out),
        .tile_out_valid(tile_out_valid), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    task automatic fail_run(input string what);
        $display("%0s", what);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Skip comment lines, then read one block; found stays 0 at end of file
    task automatic read_test(output bit found);
        int          rc;
        logic [31:0] word;
        found = 1'b0;
        rc = $fscanf(fd, "%s", tok);
        while (rc == 1 && tok == "#") begin
            rc = $fgets(rest, fd);
            rc = $fscanf(fd, "%s", tok);
        end
        if (rc != 1) begin
            return;
        end
        name = tok;
        rc = $fscanf(fd, "%d", gap_mode);
        for (int i = 0; i < LANES; i++) begin
            x_vec[i]   = '0;
            exp_vec[i] = '0;
        end
        for (int i = 0; i < 2 * `SM_TOTAL; i++) begin
            rc = $fscanf(fd, "%h", word);
            if (rc != 1) begin
                fail_run($sformatf("Test %0s in the data file is incomplete", name));
            end
            if (i < `SM_TOTAL) x_vec[i] = word;
            else exp_vec[i - `SM_TOTAL] = word;
        end
        found = 1'b1;
    endtask

    // Start pulse, then one tile per beat with optional idle cycles
    task automatic drive_vector();
        tile_t t;
        int    gaps;
        @(posedge clk);
        start <= 1'b1;
        for (int k = 0; k < `SM_DEPTH; k++) begin
            gaps = (gap_mode != 0) ? int'($urandom % 4) : 0;
            repeat (gaps) begin
                @(posedge clk);
                start         <= 1'b0;
                tile_in_valid <= 1'b0;
            end
            for (int l = 0; l < `SM_TILE; l++) begin
                t[l] = x_vec[k * `SM_TILE + l];     // Lane 0 holds the lowest index
            end
            @(posedge clk);
            start         <= 1'b0;
            tile_in       <= t;
            tile_in_valid <= 1'b1;
        end
        @(posedge clk);
        tile_in_valid <= 1'b0;
    endtask

    task automatic check_outputs();
        int    waited;
        elem_t want, got;
        waited = 0;
        @(negedge clk);
        while (!tile_out_valid) begin
            waited++;
            if (waited > WAIT_MAX) begin
                fail_run($sformatf("Timeout waiting for output in test %0s", name));
            end
            @(negedge clk);
        end
        for (int k = 0; k < `SM_DEPTH; k++) begin
            if (k > 0) begin
                @(negedge clk);                     // Beats must be back to back
                assert (tile_out_valid)
                else fail_run($sformatf("Output tile %0d missing in test %0s", k, name));
            end
            assert (!done) else fail_run("Done raised before the last output tile");
            for (int l = 0; l < `SM_TILE; l++) begin
                want = exp_vec[k * `SM_TILE + l];
                got  = elem_t'(tile_out[l]);
                assert (got == want)
                else fail_run($sformatf("error test %0s element %0d expected %h actual %h",
                                        name, k * `SM_TILE + l, want, got));
            end
        end
    endtask

    // Done is one cycle, right after the last beat
    task automatic wait_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done) begin
            waited++;
            if (waited > WAIT_MAX) begin
                fail_run($sformatf("Timeout waiting for done in test %0s", name));
            end
            @(negedge clk);
        end
        assert (waited == 0) else fail_run("Done came late after the last output tile");
        assert (!tile_out_valid) else fail_run("Extra output tile after the last one");
        @(negedge clk);
        assert (!done) else fail_run("Done stayed high for more than one cycle");
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!tile_out_valid && !done)
            else fail_run("Outputs active after reset with no start");
        end
    endtask

    initial begin
        bit found;
        rst_n         = 1'b0;
        start         = 1'b0;
        tile_in       = '0;
        tile_in_valid = 1'b0;
        n_tests       = 0;
        seed          = $urandom(32'h1f7c_10d7);    // One seed for the whole run
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        check_idle(6);
        fd = $fopen("verif/softmax_tests.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open verif/softmax_tests.txt");
        end
        read_test(found);
        while (found) begin                         // Each start follows the last done
            drive_vector();
            check_outputs();
            wait_done();
            n_tests++;
            read_test(found);
        end
        $fclose(fd);
        assert (n_tests > 0) else fail_run("No tests found in the data file");
        $display("%0d tests run", n_tests);
        $display("NO ERRORS");
        $finish;
    end

endmodule
